//--- logic/bringup_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module bringup_monitor (
    input  logic clk125M,
    input  logic reset125M,

    input  logic cam1_ready_i,
    input  logic cam1_fault_i,
    input  logic cam2_ready_i,
    input  logic cam2_fault_i,

    output logic                              all_ready_o,
    output logic                              any_fault_o,
    output logic [cam_pkg::CYCLE_COUNT_W-1:0] bringup_cycles_o
);

    localparam logic [cam_pkg::CYCLE_COUNT_W-1:0] CNT_MAX = '1;

    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            all_ready_o <= 1'b0;
            any_fault_o <= 1'b0;
        end else begin
            all_ready_o <= cam1_ready_i & cam2_ready_i;
            // Sticky until the next reset
            any_fault_o <= any_fault_o | cam1_fault_i | cam2_fault_i;
        end
    end

    // Bring-up time seen by firmware, frozen once both cameras are up
    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            bringup_cycles_o <= '0;
        end else if (!all_ready_o && bringup_cycles_o != CNT_MAX) begin
            bringup_cycles_o <= bringup_cycles_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/cam_bringup.sv
`timescale 1ns/1ps
`default_nettype none

module cam_bringup #(
    parameter int unsigned POWERUP_CYCLES    = 125000,
    parameter int unsigned INIT_DELAY_CYCLES = 125000
) (
    input  logic clk125M,
    input  logic reset125M,

    input  logic init_done_i,
    input  logic init_err_i,

    output logic pwup_o,
    output logic init_req_o,
    output logic ready_o,
    output logic fault_o
);

    localparam int unsigned CW = cam_pkg::CYCLE_COUNT_W;

    // Counter values at which power goes up and init is requested
    localparam logic [CW-1:0] PWUP_AT = CW'(POWERUP_CYCLES);
    localparam logic [CW-1:0] INIT_AT = CW'(POWERUP_CYCLES + INIT_DELAY_CYCLES);

    cam_pkg::bringup_state_t state;
    logic [CW-1:0]           delay_cnt;

    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            state      <= cam_pkg::ST_POWER_WAIT;
            delay_cnt  <= '0;
            pwup_o     <= 1'b0;
            init_req_o <= 1'b0;
        end else begin
            // Init request is a single pulse
            init_req_o <= 1'b0;

            case (state)
                cam_pkg::ST_POWER_WAIT: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == PWUP_AT) begin
                        pwup_o <= 1'b1;
                        state  <= cam_pkg::ST_INIT_WAIT_DELAY;
                    end
                end

                cam_pkg::ST_INIT_WAIT_DELAY: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == INIT_AT) begin
                        init_req_o <= 1'b1;
                        state      <= cam_pkg::ST_INIT_WAIT_DONE;
                    end
                end

                cam_pkg::ST_INIT_WAIT_DONE: begin
                    // Error beats done in the same cycle
                    if (init_err_i) begin
                        pwup_o <= 1'b0;
                        state  <= cam_pkg::ST_FAULT;
                    end else if (init_done_i) begin
                        state <= cam_pkg::ST_READY;
                    end
                end

                cam_pkg::ST_READY: begin
                    state <= cam_pkg::ST_READY;
                end

                cam_pkg::ST_FAULT: begin
                    state <= cam_pkg::ST_FAULT;
                end

                default: begin
                    state <= cam_pkg::ST_FAULT;
                end
            endcase
        end
    end

    // Verdict flags follow the terminal states
    assign ready_o = (state == cam_pkg::ST_READY);
    assign fault_o = (state == cam_pkg::ST_FAULT);

endmodule

`default_nettype wire

//--- logic/cam_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module cam_ctrl_top #(
    parameter int unsigned POWERUP_CYCLES    = 125000,
    parameter int unsigned INIT_DELAY_CYCLES = 125000
) (
    input  logic clk125M,
    input  logic reset125M,

    // Camera 1
    input  logic cam1_init_done_i,
    input  logic cam1_init_err_i,
    output logic cam1_pwup_o,
    output logic cam1_init_req_o,

    // Camera 2
    input  logic cam2_init_done_i,
    input  logic cam2_init_err_i,
    output logic cam2_pwup_o,
    output logic cam2_init_req_o,

    // Bring-up status
    output logic                              all_ready_o,
    output logic                              any_fault_o,
    output logic [cam_pkg::CYCLE_COUNT_W-1:0] bringup_cycles_o,

    // Write sources
    input  cam_pkg::wr_data_t video_data_i,
    input  logic              video_data_we_i,
    input  cam_pkg::wr_ctrl_t video_ctrl_i,
    input  logic              video_ctrl_we_i,
    input  cam_pkg::wr_data_t dbg_data_i,
    input  logic              dbg_data_we_i,
    input  cam_pkg::wr_ctrl_t dbg_ctrl_i,
    input  logic              dbg_ctrl_we_i,
    input  logic              dbg_kick_i,

    // Write FIFO side
    output cam_pkg::wr_data_t fifo_data_o,
    output logic              fifo_data_we_o,
    output cam_pkg::wr_ctrl_t fifo_ctrl_o,
    output logic              fifo_ctrl_we_o,
    output logic              read_kick_o
);

    logic cam1_ready;
    logic cam1_fault;
    logic cam2_ready;
    logic cam2_fault;

    cam_bringup #(
        .POWERUP_CYCLES   (POWERUP_CYCLES),
        .INIT_DELAY_CYCLES(INIT_DELAY_CYCLES)
    ) u_cam1_bringup (
        .clk125M    (clk125M),
        .reset125M  (reset125M),
        .init_done_i(cam1_init_done_i),
        .init_err_i (cam1_init_err_i),
        .pwup_o     (cam1_pwup_o),
        .init_req_o (cam1_init_req_o),
        .ready_o    (cam1_ready),
        .fault_o    (cam1_fault)
    );

    cam_bringup #(
        .POWERUP_CYCLES   (POWERUP_CYCLES),
        .INIT_DELAY_CYCLES(INIT_DELAY_CYCLES)
    ) u_cam2_bringup (
        .clk125M    (clk125M),
        .reset125M  (reset125M),
        .init_done_i(cam2_init_done_i),
        .init_err_i (cam2_init_err_i),
        .pwup_o     (cam2_pwup_o),
        .init_req_o (cam2_init_req_o),
        .ready_o    (cam2_ready),
        .fault_o    (cam2_fault)
    );

    bringup_monitor u_bringup_monitor (
        .clk125M         (clk125M),
        .reset125M       (reset125M),
        .cam1_ready_i    (cam1_ready),
        .cam1_fault_i    (cam1_fault),
        .cam2_ready_i    (cam2_ready),
        .cam2_fault_i    (cam2_fault),
        .all_ready_o     (all_ready_o),
        .any_fault_o     (any_fault_o),
        .bringup_cycles_o(bringup_cycles_o)
    );

    dram_request_merge u_dram_request_merge (
        .clk125M        (clk125M),
        .reset125M      (reset125M),
        .video_data_i   (video_data_i),
        .video_data_we_i(video_data_we_i),
        .video_ctrl_i   (video_ctrl_i),
        .video_ctrl_we_i(video_ctrl_we_i),
        .dbg_data_i     (dbg_data_i),
        .dbg_data_we_i  (dbg_data_we_i),
        .dbg_ctrl_i     (dbg_ctrl_i),
        .dbg_ctrl_we_i  (dbg_ctrl_we_i),
        .dbg_kick_i     (dbg_kick_i),
        .fifo_data_o    (fifo_data_o),
        .fifo_data_we_o (fifo_data_we_o),
        .fifo_ctrl_o    (fifo_ctrl_o),
        .fifo_ctrl_we_o (fifo_ctrl_we_o),
        .read_kick_o    (read_kick_o)
    );

endmodule

`default_nettype wire

//--- logic/cam_pkg.sv
`default_nettype none

package cam_pkg;

    localparam int DATA_W        = 32;
    localparam int STRB_W        = 4;
    localparam int LEN_W         = 8;
    localparam int ADDR_W        = 32;
    localparam int CYCLE_COUNT_W = 32;

    // Write FIFO data word, data above strobe
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } wr_data_t;

    // Write FIFO control word, burst length above address
    typedef struct packed {
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] addr;
    } wr_ctrl_t;

    typedef enum logic [2:0] {
        ST_POWER_WAIT,
        ST_INIT_WAIT_DELAY,
        ST_INIT_WAIT_DONE,
        ST_READY,
        ST_FAULT
    } bringup_state_t;

endpackage

`default_nettype wire

//--- logic/dram_request_merge.sv
`timescale 1ns/1ps
`default_nettype none

module dram_request_merge (
    input  logic clk125M,
    input  logic reset125M,

    // Video path writes
    input  cam_pkg::wr_data_t video_data_i,
    input  logic              video_data_we_i,
    input  cam_pkg::wr_ctrl_t video_ctrl_i,
    input  logic              video_ctrl_we_i,

    // Debug console levels
    input  cam_pkg::wr_data_t dbg_data_i,
    input  logic              dbg_data_we_i,
    input  cam_pkg::wr_ctrl_t dbg_ctrl_i,
    input  logic              dbg_ctrl_we_i,
    input  logic              dbg_kick_i,

    // Write FIFO port and read kick
    output cam_pkg::wr_data_t fifo_data_o,
    output logic              fifo_data_we_o,
    output cam_pkg::wr_ctrl_t fifo_ctrl_o,
    output logic              fifo_ctrl_we_o,
    output logic              read_kick_o
);

    // Bit 0 data write, bit 1 control write, bit 2 read kick
    logic [2:0] dbg_level;
    logic [2:0] dbg_level_d;
    logic [2:0] dbg_pulse;

    assign dbg_level = {dbg_kick_i, dbg_ctrl_we_i, dbg_data_we_i};

    always_ff @(posedge clk125M) begin
        if (reset125M) begin
            dbg_level_d <= 3'b000;
            dbg_pulse   <= 3'b000;
        end else begin
            dbg_level_d <= dbg_level;
            // Rising edge only, long holds give one pulse
            dbg_pulse   <= dbg_level & ~dbg_level_d;
        end
    end

    // Video wins, a colliding debug pulse is dropped
    assign fifo_data_o    = video_data_we_i ? video_data_i : dbg_data_i;
    assign fifo_data_we_o = video_data_we_i | dbg_pulse[0];

    assign fifo_ctrl_o    = video_ctrl_we_i ? video_ctrl_i : dbg_ctrl_i;
    assign fifo_ctrl_we_o = video_ctrl_we_i | dbg_pulse[1];

    assign read_kick_o = dbg_pulse[2];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the camera controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_cam_ctrl -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_cam_ctrl)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Verification passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- testbench/cam_ctrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cam_ctrl_sva (
    input logic              clk125M,
    input logic              reset125M,
    input logic              cam1_init_req_i,
    input logic              cam2_init_req_i,
    input logic              all_ready_i,
    input logic              any_fault_i,
    input cam_pkg::wr_data_t video_data_i,
    input logic              video_data_we_i,
    input cam_pkg::wr_ctrl_t video_ctrl_i,
    input logic              video_ctrl_we_i,
    input cam_pkg::wr_data_t fifo_data_i,
    input logic              fifo_data_we_i,
    input cam_pkg::wr_ctrl_t fifo_ctrl_i,
    input logic              fifo_ctrl_we_i
);

    // Init request is a one-cycle pulse
    assert property (@(posedge clk125M) disable iff (reset125M)
        cam1_init_req_i |=> !cam1_init_req_i)
        else $error("cam1 init request held for more than one cycle");

    assert property (@(posedge clk125M) disable iff (reset125M)
        cam2_init_req_i |=> !cam2_init_req_i)
        else $error("cam2 init request held for more than one cycle");

    assert property (@(posedge clk125M) disable iff (reset125M)
        !(all_ready_i && any_fault_i))
        else $error("all ready and any fault are high together");

    // Video path owns the FIFO port when its strobe is high
    assert property (@(posedge clk125M) disable iff (reset125M)
        video_data_we_i |-> (fifo_data_we_i && fifo_data_i == video_data_i))
        else $error("video data write not carried on the FIFO port");

    assert property (@(posedge clk125M) disable iff (reset125M)
        video_ctrl_we_i |-> (fifo_ctrl_we_i && fifo_ctrl_i == video_ctrl_i))
        else $error("video control write not carried on the FIFO port");

endmodule

bind cam_ctrl_top cam_ctrl_sva u_cam_ctrl_sva (
    .clk125M        (clk125M),
    .reset125M      (reset125M),
    .cam1_init_req_i(cam1_init_req_o),
    .cam2_init_req_i(cam2_init_req_o),
    .all_ready_i    (all_ready_o),
    .any_fault_i    (any_fault_o),
    .video_data_i   (video_data_i),
    .video_data_we_i(video_data_we_i),
    .video_ctrl_i   (video_ctrl_i),
    .video_ctrl_we_i(video_ctrl_we_i),
    .fifo_data_i    (fifo_data_o),
    .fifo_data_we_i (fifo_data_we_o),
    .fifo_ctrl_i    (fifo_ctrl_o),
    .fifo_ctrl_we_i (fifo_ctrl_we_o)
);

`default_nettype wire

//--- testbench/tb_cam_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cam_ctrl;

    localparam int POWERUP         = 20;
    localparam int INIT_DELAY      = 15;
    localparam int REQ_AT          = POWERUP + INIT_DELAY;
    localparam int WATCHDOG_CYCLES = 2 * (POWERUP + INIT_DELAY + 64) + 2000;

    logic                              clk125M;
    logic                              reset125M;
    logic                              cam1_init_done_i;
    logic                              cam1_init_err_i;
    logic                              cam1_pwup_o;
    logic                              cam1_init_req_o;
    logic                              cam2_init_done_i;
    logic                              cam2_init_err_i;
    logic                              cam2_pwup_o;
    logic                              cam2_init_req_o;
    logic                              all_ready_o;
    logic                              any_fault_o;
    logic [cam_pkg::CYCLE_COUNT_W-1:0] bringup_cycles_o;
    cam_pkg::wr_data_t                 video_data_i;
    logic                              video_data_we_i;
    cam_pkg::wr_ctrl_t                 video_ctrl_i;
    logic                              video_ctrl_we_i;
    cam_pkg::wr_data_t                 dbg_data_i;
    logic                              dbg_data_we_i;
    cam_pkg::wr_ctrl_t                 dbg_ctrl_i;
    logic                              dbg_ctrl_we_i;
    logic                              dbg_kick_i;
    cam_pkg::wr_data_t                 fifo_data_o;
    logic                              fifo_data_we_o;
    cam_pkg::wr_ctrl_t                 fifo_ctrl_o;
    logic                              fifo_ctrl_we_o;
    logic                              read_kick_o;

    integer seed;
    string  test_name;

    cam_ctrl_top #(
        .POWERUP_CYCLES   (POWERUP),
        .INIT_DELAY_CYCLES(INIT_DELAY)
    ) i_cam_ctrl_top (.*);

    initial begin
        clk125M = 1'b0;
        forever #4 clk125M = ~clk125M;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk125M);
        $display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    task automatic expect_equal(input string label, input logic [63:0] exp,
                                input logic [63:0] act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %0h, actual %0h", test_name, label, exp, act);
            $display("Verification failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    task automatic reset_dut();
        @(posedge clk125M);
        reset125M        <= 1'b1;
        cam1_init_done_i <= 1'b0;
        cam1_init_err_i  <= 1'b0;
        cam2_init_done_i <= 1'b0;
        cam2_init_err_i  <= 1'b0;
        repeat (8) @(posedge clk125M);
        reset125M <= 1'b0;
    endtask

    // Cycle c is the cycle after the c-th clock edge with reset low
    task automatic run_cameras(input bit inject_fault);
        int c;
        int d1;
        int d2;
        int ready_at;
        test_name = inject_fault ? "cam2_fault" : "bringup";
        d1 = REQ_AT + rand_below(41);
        d2 = REQ_AT + rand_below(41);
        ready_at = inject_fault ? 100000 : ((d1 > d2) ? d1 : d2) + 2;
        for (c = 0; c < 130; c++) begin
            @(posedge clk125M);
            cam1_init_done_i <= (c >= d1);
            // Faulty camera shows done together with error for one cycle
            cam2_init_done_i <= inject_fault ? (c == d2) : (c >= d2);
            cam2_init_err_i  <= inject_fault && (c >= d2);
            @(negedge clk125M);
            expect_equal("cam1_pwup_o", 64'(c >= POWERUP), 64'(cam1_pwup_o));
            expect_equal("cam2_pwup_o", 64'(c >= POWERUP && !(inject_fault && c > d2)),
                         64'(cam2_pwup_o));
            expect_equal("cam1_init_req_o", 64'(c == REQ_AT), 64'(cam1_init_req_o));
            expect_equal("cam2_init_req_o", 64'(c == REQ_AT), 64'(cam2_init_req_o));
            expect_equal("cam1 ready", 64'(c > d1),
                         64'(i_cam_ctrl_top.u_cam1_bringup.ready_o));
            expect_equal("any_fault_o", 64'(inject_fault && c >= d2 + 2), 64'(any_fault_o));
            expect_equal("all_ready_o", 64'(c >= ready_at), 64'(all_ready_o));
            // Count stops on the edge where all ready is first seen high
            expect_equal("bringup_cycles_o", 64'(((c < ready_at) ? c : ready_at) + 1),
                         64'(bringup_cycles_o));
        end
    endtask

    task automatic run_merge();
        int                c;
        logic [31:0]       r;
        logic [63:0]       r64;
        logic [2:0]        lvl;
        logic [2:0]        lvl_p1;
        logic [2:0]        lvl_p2;
        logic [2:0]        pulse;
        cam_pkg::wr_data_t v_data;
        cam_pkg::wr_data_t d_data;
        cam_pkg::wr_ctrl_t v_ctrl;
        cam_pkg::wr_ctrl_t d_ctrl;
        test_name = "merge";
        lvl    = 3'b000;
        lvl_p1 = 3'b000;
        lvl_p2 = 3'b000;
        for (c = 0; c < 1000; c++) begin
            @(posedge clk125M);
            r = $random(seed);
            lvl_p2 = lvl_p1;
            lvl_p1 = lvl;
            // Kick level flips rarely, so it sees long holds
            lvl = lvl ^ {r[7:4] == 4'd0, r[3:2] == 2'd0, r[1:0] == 2'd0};
            r64 = {$random(seed), $random(seed)};
            v_data = r64[35:0];
            d_data = r64[63:28];
            r64 = {$random(seed), $random(seed)};
            v_ctrl = r64[39:0];
            d_ctrl = r64[63:24];
            video_data_we_i <= r[8];
            video_ctrl_we_i <= r[9];
            video_data_i    <= v_data;
            video_ctrl_i    <= v_ctrl;
            dbg_data_i      <= d_data;
            dbg_ctrl_i      <= d_ctrl;
            dbg_data_we_i   <= lvl[0];
            dbg_ctrl_we_i   <= lvl[1];
            dbg_kick_i      <= lvl[2];
            @(negedge clk125M);
            pulse = lvl_p1 & ~lvl_p2;
            expect_equal("fifo_data_we_o", 64'(r[8] | pulse[0]), 64'(fifo_data_we_o));
            if (r[8] | pulse[0]) begin
                expect_equal("fifo_data_o", 64'(r[8] ? v_data : d_data), 64'(fifo_data_o));
            end
            expect_equal("fifo_ctrl_we_o", 64'(r[9] | pulse[1]), 64'(fifo_ctrl_we_o));
            if (r[9] | pulse[1]) begin
                expect_equal("fifo_ctrl_o", 64'(r[9] ? v_ctrl : d_ctrl), 64'(fifo_ctrl_o));
            end
            expect_equal("read_kick_o", 64'(pulse[2]), 64'(read_kick_o));
        end
    endtask

    initial begin
        seed             = 32'h0dbd_0a4f;
        test_name        = "reset";
        reset125M        = 1'b1;
        cam1_init_done_i = 1'b0;
        cam1_init_err_i  = 1'b0;
        cam2_init_done_i = 1'b0;
        cam2_init_err_i  = 1'b0;
        video_data_i     = '0;
        video_data_we_i  = 1'b0;
        video_ctrl_i     = '0;
        video_ctrl_we_i  = 1'b0;
        dbg_data_i       = '0;
        dbg_data_we_i    = 1'b0;
        dbg_ctrl_i       = '0;
        dbg_ctrl_we_i    = 1'b0;
        dbg_kick_i       = 1'b0;
        repeat (8) @(posedge clk125M);
        reset125M <= 1'b0;
        run_cameras(1'b0);
        reset_dut();
        run_cameras(1'b1);
        run_merge();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/cam_pkg.sv
logic/cam_bringup.sv
logic/bringup_monitor.sv
logic/dram_request_merge.sv
logic/cam_ctrl_top.sv
testbench/cam_ctrl_sva.sv
testbench/tb_cam_ctrl.sv
